/* calc_pkg.sv */
package calc_pkg;

   localparam int data_w   = 8;
   localparam int result_w = 16;

   // Controller state, doubling as the operation code sent to the pipeline.
   typedef enum logic [3:0] {
      func_idle   = 4'd0,
      func_load_a = 4'd1,
      func_add    = 4'd2,
      func_sub    = 4'd3,
      func_mul    = 4'd4,
      func_add_s  = 4'd10,
      func_sub_s  = 4'd11,
      func_mul_s  = 4'd12
   } func_t;

   typedef enum logic [1:0] {
      reg_hold   = 2'd0,
      reg_load_a = 2'd1,
      reg_load_b = 2'd3
   } reg_ctrl_t;

   // ~~~~~~~~~~~~~~~~~~~~
   // Pipeline payloads.
   typedef struct packed {
      func_t             func;
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
   } op_t;

   typedef struct packed {
      func_t               func;
      logic [result_w-1:0] result;
   } res_t;

   // ~~~~~~~~~~~~~~~~~~~~
   function automatic logic func_is_op(func_t f);
      return f inside {func_add, func_sub, func_mul, func_add_s, func_sub_s, func_mul_s};
   endfunction

   function automatic logic func_is_signed(func_t f);
      return f inside {func_add_s, func_sub_s, func_mul_s};
   endfunction

endpackage

/* alu_req_if.sv */
`timescale 1ns/10ps

// One request from the controller to the arithmetic pipeline.
interface alu_req_if;

   logic            valid;
   logic            ready;
   calc_pkg::op_t   op;

   modport ctrl (
      output valid,
      output op,
      input  ready
   );

   modport alu (
      input  valid,
      input  op,
      output ready
   );

endinterface

/* button_edge.sv */
`timescale 1ns/10ps

module button_edge (
   input  logic clk,
   input  logic rst_n,
   input  logic btn,
   output logic pulse
);

   logic [1:0] sync;
   logic       delayed;

   // Two flops into the clock domain and one more to find the rising edge.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync    <= 2'b00;
         delayed <= 1'b0;
         pulse   <= 1'b0;
      end else begin
         sync    <= {sync[0], btn};
         delayed <= sync[1];
         pulse   <= sync[1] & ~delayed;
      end
   end

endmodule

/* pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     full;
   payload_t data;

   // Room when empty or when the held item leaves this cycle.
   assign in_ready = !full || out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data <= in_data;
      end
   end

   assign out_valid = full;
   assign out_data  = data;

endmodule

/* alu_ctrl.sv */
`timescale 1ns/10ps

module alu_ctrl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enter_pulse,
   input  logic                        sign_pulse,
   input  logic [calc_pkg::data_w-1:0] switches,
   output calc_pkg::func_t             func,
   output calc_pkg::reg_ctrl_t         reg_ctrl,
   alu_req_if.ctrl                     req
);

   calc_pkg::func_t             state;
   calc_pkg::func_t             next_state;
   calc_pkg::reg_ctrl_t         i_reg;
   calc_pkg::reg_ctrl_t         next_i_reg;
   logic [calc_pkg::data_w-1:0] a_reg;
   logic [calc_pkg::data_w-1:0] a_next;
   logic                        accept;
   logic                        issue;

   // ~~~~~~~~~~~~~~~~~~~~
   // Operation select FSM.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= calc_pkg::func_idle;
         i_reg <= calc_pkg::reg_hold;
      end else begin
         state <= next_state;
         i_reg <= next_i_reg;
      end
   end

   // Pulses are dropped while a request waits. Enter wins over sign.
   always_comb begin
      next_state = state;
      next_i_reg = i_reg;
      if (!req.valid) begin
         if (enter_pulse) begin
            case (state)
               calc_pkg::func_idle: begin
                  next_state = calc_pkg::func_load_a;
                  next_i_reg = calc_pkg::reg_load_a;
               end
               calc_pkg::func_load_a: begin
                  next_state = calc_pkg::func_add;
                  next_i_reg = calc_pkg::reg_load_b;
               end
               calc_pkg::func_add:   next_state = calc_pkg::func_sub;
               calc_pkg::func_sub:   next_state = calc_pkg::func_mul;
               calc_pkg::func_mul:   next_state = calc_pkg::func_add;
               calc_pkg::func_add_s: next_state = calc_pkg::func_sub_s;
               calc_pkg::func_sub_s: next_state = calc_pkg::func_mul_s;
               calc_pkg::func_mul_s: next_state = calc_pkg::func_add_s;
               default:              next_state = calc_pkg::func_idle;
            endcase
         end else if (sign_pulse) begin
            case (state)
               calc_pkg::func_idle:   next_state = calc_pkg::func_idle;
               calc_pkg::func_load_a: next_state = calc_pkg::func_load_a;
               calc_pkg::func_add:    next_state = calc_pkg::func_add_s;
               calc_pkg::func_sub:    next_state = calc_pkg::func_sub_s;
               calc_pkg::func_mul:    next_state = calc_pkg::func_mul_s;
               calc_pkg::func_add_s:  next_state = calc_pkg::func_add;
               calc_pkg::func_sub_s:  next_state = calc_pkg::func_sub;
               calc_pkg::func_mul_s:  next_state = calc_pkg::func_mul;
               default:               next_state = calc_pkg::func_idle;
            endcase
         end
      end
   end

   assign func     = state;
   assign reg_ctrl = i_reg;

   // ~~~~~~~~~~~~~~~~~~~~
   // Operand A tracks the switches until B capture starts.
   assign a_next = (i_reg == calc_pkg::reg_load_a) ? switches : a_reg;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_reg <= '0;
      end else begin
         a_reg <= a_next;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Request issue.
   assign accept = !req.valid && (enter_pulse || sign_pulse);
   assign issue  = accept && calc_pkg::func_is_op(next_state);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req.valid <= 1'b0;
      end else if (issue) begin
         req.valid <= 1'b1;
      end else if (req.ready) begin
         req.valid <= 1'b0;
      end
   end

   // B comes from the switches at the issuing edge.
   always_ff @(posedge clk) begin
      if (issue) begin
         req.op.func <= next_state;
         req.op.a    <= a_next;
         req.op.b    <= switches;
      end
   end

endmodule

/* alu_pipe.sv */
`timescale 1ns/10ps

module alu_pipe (
   input  logic                          clk,
   input  logic                          rst_n,
   alu_req_if.alu                        req,
   output logic                          result_valid,
   input  logic                          result_ready,
   output logic [calc_pkg::result_w-1:0] result,
   output calc_pkg::func_t               result_func
);

   localparam int ext_w = calc_pkg::result_w - calc_pkg::data_w;

   calc_pkg::op_t                 s1_data;
   logic                          s1_valid;
   logic                          s1_ready;
   calc_pkg::res_t                s2_in;
   calc_pkg::res_t                s2_data;
   logic                          sgn;
   logic [calc_pkg::result_w-1:0] a_ext;
   logic [calc_pkg::result_w-1:0] b_ext;

   // ~~~~~~~~~~~~~~~~~~~~
   // Stage 1 holds the request.
   pipe_reg #(.payload_t(calc_pkg::op_t)) stage1 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (req.valid),
      .in_ready  (req.ready),
      .in_data   (req.op),
      .out_valid (s1_valid),
      .out_ready (s1_ready),
      .out_data  (s1_data)
   );

   // ~~~~~~~~~~~~~~~~~~~~
   // Extend and compute.
   assign sgn   = calc_pkg::func_is_signed(s1_data.func);
   assign a_ext = {{ext_w{sgn & s1_data.a[calc_pkg::data_w-1]}}, s1_data.a};
   assign b_ext = {{ext_w{sgn & s1_data.b[calc_pkg::data_w-1]}}, s1_data.b};

   always_comb begin
      s2_in.func = s1_data.func;
      case (s1_data.func)
         calc_pkg::func_add,
         calc_pkg::func_add_s: s2_in.result = a_ext + b_ext;
         calc_pkg::func_sub,
         calc_pkg::func_sub_s: s2_in.result = a_ext - b_ext;
         calc_pkg::func_mul,
         calc_pkg::func_mul_s: s2_in.result = a_ext * b_ext;  // low half only
         default:              s2_in.result = '0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Stage 2 drives the result handshake.
   pipe_reg #(.payload_t(calc_pkg::res_t)) stage2 (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (s1_valid),
      .in_ready  (s1_ready),
      .in_data   (s2_in),
      .out_valid (result_valid),
      .out_ready (result_ready),
      .out_data  (s2_data)
   );

   assign result      = s2_data.result;
   assign result_func = s2_data.func;

endmodule

/* calc_top.sv */
`timescale 1ns/10ps

module calc_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          enter,
   input  logic                          sign,
   input  logic [calc_pkg::data_w-1:0]   switches,
   output logic [3:0]                    func,
   output logic [1:0]                    reg_ctrl,
   output logic                          result_valid,
   input  logic                          result_ready,
   output logic [calc_pkg::result_w-1:0] result,
   output logic [3:0]                    result_func
);

   logic enter_pulse;
   logic sign_pulse;

   alu_req_if req_bus ();

   // ~~~~~~~~~~~~~~~~~~~~
   // Button inputs.
   button_edge enter_edge (
      .clk   (clk),
      .rst_n (rst_n),
      .btn   (enter),
      .pulse (enter_pulse)
   );

   button_edge sign_edge (
      .clk   (clk),
      .rst_n (rst_n),
      .btn   (sign),
      .pulse (sign_pulse)
   );

   // ~~~~~~~~~~~~~~~~~~~~
   // Controller and arithmetic.
   alu_ctrl ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .enter_pulse (enter_pulse),
      .sign_pulse  (sign_pulse),
      .switches    (switches),
      .func        (func),
      .reg_ctrl    (reg_ctrl),
      .req         (req_bus.ctrl)
   );

   alu_pipe pipe (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req_bus.alu),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result),
      .result_func  (result_func)
   );

endmodule

/* tb_calc.sv */
`timescale 1ns/10ps

module tb_calc;

   localparam int n_presses      = 38;
   localparam int timeout_cycles = n_presses * 20 + 200;
   // Bit i set means press i of the signed sequence is an enter press.
   localparam logic [7:0] signed_seq = 8'b1001_0010;

   logic                          clk;
   logic                          rst_n;
   logic                          enter;
   logic                          sign;
   logic [calc_pkg::data_w-1:0]   switches;
   logic [3:0]                    func;
   logic [1:0]                    reg_ctrl;
   logic                          result_valid;
   logic                          result_ready;
   logic [calc_pkg::result_w-1:0] result;
   logic [3:0]                    result_func;

   integer                        seed = 75;
   int                            seq_errors = 0;
   int                            res_errors = 0;
   int                            cycle = 0;
   int                            rdy_mode = 0;
   logic [31:0]                   ready_bits = '0;
   logic [3:0]                    m_state = 4'd0;
   logic [1:0]                    m_reg = 2'd0;
   logic [calc_pkg::data_w-1:0]   m_a = '0;
   logic [calc_pkg::result_w-1:0] exp_res_q[$];
   logic [3:0]                    exp_func_q[$];
   int                            mark_q[$];

   calc_top DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .enter        (enter),
      .sign         (sign),
      .switches     (switches),
      .func         (func),
      .reg_ctrl     (reg_ctrl),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result),
      .result_func  (result_func)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Reference model.
   function automatic logic [3:0] next_func(input logic [3:0] f, input logic is_enter);
      logic [3:0] n;
      case (f)
         calc_pkg::func_idle:   n = is_enter ? calc_pkg::func_load_a : calc_pkg::func_idle;
         calc_pkg::func_load_a: n = is_enter ? calc_pkg::func_add : calc_pkg::func_load_a;
         calc_pkg::func_add:    n = is_enter ? calc_pkg::func_sub : calc_pkg::func_add_s;
         calc_pkg::func_sub:    n = is_enter ? calc_pkg::func_mul : calc_pkg::func_sub_s;
         calc_pkg::func_mul:    n = is_enter ? calc_pkg::func_add : calc_pkg::func_mul_s;
         calc_pkg::func_add_s:  n = is_enter ? calc_pkg::func_sub_s : calc_pkg::func_add;
         calc_pkg::func_sub_s:  n = is_enter ? calc_pkg::func_mul_s : calc_pkg::func_sub;
         calc_pkg::func_mul_s:  n = is_enter ? calc_pkg::func_add_s : calc_pkg::func_mul;
         default:               n = calc_pkg::func_idle;
      endcase
      return n;
   endfunction

   function automatic logic is_operation(input logic [3:0] f);
      return (f >= 4'd2 && f <= 4'd4) || (f >= 4'd10 && f <= 4'd12);
   endfunction

   function automatic logic [15:0] expected_result(input logic [3:0] f, input logic [7:0] a,
                                                   input logic [7:0] b);
      int ia;
      int ib;
      int r;
      if (f >= 4'd10) begin
         ia = int'($signed(a));
         ib = int'($signed(b));
      end else begin
         ia = int'(a);
         ib = int'(b);
      end
      case (f)
         4'd2, 4'd10: r = ia + ib;
         4'd3, 4'd11: r = ia - ib;
         4'd4, 4'd12: r = ia * ib;
         default:     r = 0;
      endcase
      return r[15:0];
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp, inout int count);
      if (got !== exp) begin
         $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
         count++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // Stimulus tasks.
   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (10) @(posedge clk);
      rst_n   <= 1'b1;
      m_state = 4'd0;
      m_reg   = 2'd0;
      m_a     = '0;
      @(negedge clk);
   endtask

   task automatic press(input logic is_enter, input logic [7:0] val, input int hold);
      int         mark;
      logic [3:0] nxt;
      @(posedge clk);
      if (is_enter)
         enter <= 1'b1;
      else
         sign <= 1'b1;
      switches <= val;
      mark = cycle + 1;
      repeat (3) @(posedge clk);
      // The pulse acts on the next edge, where a waiting request blocks it.
      if (exp_res_q.size() < 3) begin
         if (m_reg == 2'd1)
            m_a = val;
         nxt = next_func(m_state, is_enter);
         if (is_enter && m_state == 4'd0)
            m_reg = 2'd1;
         else if (is_enter && m_state == 4'd1)
            m_reg = 2'd3;
         m_state = nxt;
         if (is_operation(nxt)) begin
            exp_res_q.push_back(expected_result(nxt, m_a, val));
            exp_func_q.push_back(nxt);
            mark_q.push_back(rdy_mode == 0 ? mark : -1);
         end
      end
      repeat (hold - 3) @(posedge clk);
      enter <= 1'b0;
      sign  <= 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_value("func", 16'(func), 16'(m_state), seq_errors);
      check_value("reg_ctrl", 16'(reg_ctrl), 16'(m_reg), seq_errors);
   endtask

   task automatic drain_results();
      int n;
      n = 0;
      while (exp_res_q.size() != 0 && n < 50) begin
         @(posedge clk);
         n++;
      end
      @(negedge clk);
   endtask

   // Result sink with the chosen back-pressure pattern.
   initial begin
      result_ready = 1'b1;
      forever begin
         @(posedge clk);
         if (rdy_mode == 0)
            result_ready <= 1'b1;
         else if (rdy_mode == 1)
            result_ready <= 1'b0;
         else
            result_ready <= ready_bits[cycle[4:0]];
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Compare each transferred result with the head of the queue.
   always @(negedge clk) begin : compare_results
      int mark;
      if (rst_n && result_valid && result_ready) begin
         if (exp_res_q.size() == 0) begin
            $display("Result 0x%h arrived with no request outstanding", result);
            res_errors++;
         end else begin
            mark = mark_q.pop_front();
            check_value("result", result, exp_res_q.pop_front(), res_errors);
            check_value("result_func", 16'(result_func), 16'(exp_func_q.pop_front()),
                        res_errors);
            if (mark >= 0 && cycle - mark != 6) begin
               $display("Result came %0d cycles after the press instead of 6", cycle - mark);
               res_errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= timeout_cycles) begin
         $display("Run did not finish within %0d cycles, %0d sequence and %0d result errors",
                  timeout_cycles, seq_errors, res_errors);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      logic [calc_pkg::data_w-1:0] val;
      logic                        use_enter;
      int                          i;
      rst_n    = 1'b0;
      enter    = 1'b0;
      sign     = 1'b0;
      switches = '0;
      apply_reset();

      check_value("func", 16'(func), 16'h0000, seq_errors);
      check_value("reg_ctrl", 16'(reg_ctrl), 16'h0000, seq_errors);
      press(1'b0, 8'h00, 5);
      press(1'b0, 8'h00, 5);
      check_value("result_valid", 16'(result_valid), 16'h0000, seq_errors);
      press(1'b1, 8'h33, 5);
      check_value("func", 16'(func), 16'h0001, seq_errors);
      check_value("reg_ctrl", 16'(reg_ctrl), 16'h0001, seq_errors);
      press(1'b0, 8'h44, 5);
      press(1'b1, 8'h05, 5);
      check_value("func", 16'(func), 16'h0002, seq_errors);
      check_value("reg_ctrl", 16'(reg_ctrl), 16'h0003, seq_errors);

      // Unsigned cycle back to add. A is small so the subtraction wraps.
      press(1'b1, 8'h80 | 8'($random(seed)), 5);
      press(1'b1, 8'($random(seed)), 5);
      press(1'b1, 8'($random(seed)), 5);
      press(1'b1, 8'($random(seed)), 5);

      // Signed cycle with a negative A.
      drain_results();
      apply_reset();
      press(1'b1, 8'($random(seed)), 5);
      press(1'b1, 8'h80 | 8'($random(seed)), 5);
      for (i = 0; i < 8; i++) begin
         val = 8'($random(seed));
         if (i % 2 == 0)
            val[7] = 1'b1;
         press(signed_seq[i], val, 5);
      end
      // Sign on signed add goes back to unsigned add.
      press(1'b0, 8'($random(seed)), 5);

      // Latency is checked on every result while ready stays high.
      for (i = 0; i < 3; i++)
         press(1'b1, 8'($random(seed)), 5);

      // ~~~~~~~~~~~~~~~~~~~~
      // Back-pressure.
      drain_results();
      rdy_mode = 1;
      for (i = 0; i < 5; i++)
         press(1'b1, 8'($random(seed)), 5);
      ready_bits = $random(seed);
      rdy_mode   = 2;
      for (i = 0; i < 8; i++) begin
         use_enter = 1'($random(seed));
         val       = 8'($random(seed));
         press(use_enter, val, 5);
      end
      rdy_mode = 0;
      drain_results();

      // A long hold advances the state once.
      press(1'b1, 8'($random(seed)), 40);
      press(1'b0, 8'($random(seed)), 5);
      drain_results();

      if (exp_res_q.size() != 0) begin
         $display("%0d expected results never arrived", exp_res_q.size());
         seq_errors++;
      end
      $display("Finished after %0d cycles with %0d sequence and %0d result errors",
               cycle, seq_errors, res_errors);
      if (seq_errors + res_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* tb.f */
calc_pkg.sv
alu_req_if.sv
button_edge.sv
pipe_reg.sv
alu_ctrl.sv
alu_pipe.sv
calc_top.sv
tb_calc.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module tb_calc -o tb_calc \
   && ./obj_dir/tb_calc > sim.log 2>&1 \
   || echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
